//--- stb_cfg.svh
// Store buffer configuration
`ifndef STB_CFG_SVH
`define STB_CFG_SVH

// Number of queue entries, must be a power of two
`define STB_DEPTH 4

// Address width toward cache
`define STB_ADDR_W 32

// Data width of one store
`define STB_DATA_W 32

// One byte select per data byte
`define STB_SEL_W (`STB_DATA_W / 8)

`endif

//--- stb_pkg.sv
// Store buffer shared types
`include "stb_cfg.svh"

package stb_pkg;

    // One buffered store, as written to the cache
    typedef struct packed {
        logic [`STB_ADDR_W-1:0] addr;
        logic [`STB_DATA_W-1:0] wdata;
        logic [`STB_SEL_W-1:0]  sel_byte;
    } stb_entry_t;

    // Slot index, wraps naturally at depth
    typedef logic [$clog2(`STB_DEPTH)-1:0] stb_ptr_t;

    // LSU side FSM
    typedef enum logic {
        LSU_IDLE = 1'b0,
        // Entry written, ack pending
        LSU_ACK  = 1'b1
    } lsu_state_e;

    // Drain side FSM
    typedef enum logic {
        DRAIN_IDLE = 1'b0,
        // Head entry on cache port
        DRAIN_REQ  = 1'b1
    } drain_state_e;

endpackage

//--- stb_ctrl_if.sv
// Queue control and status bundle
`timescale 1ns/1ps

interface stb_ctrl_if;

    // Push from LSU side
    logic wr_en;
    // Pop from drain side
    logic rd_en;
    // Queue status
    logic full;
    logic empty;

    // Store acceptance
    modport lsu_mp (
        output wr_en,
        input  full
    );

    // Cache drain
    modport drain_mp (
        output rd_en,
        input  empty
    );

    // Pointer and occupancy keeper
    modport ptr_mp (
        input  wr_en,
        input  rd_en,
        output full,
        output empty
    );

endinterface

//--- stb_ptr_counter.sv
// Store buffer pointers and occupancy
`timescale 1ns/1ps
`include "stb_cfg.svh"

module stb_ptr_counter
    import stb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    stb_ctrl_if.ptr_mp ctrl,
    output stb_ptr_t   wr_ptr_o,
    output stb_ptr_t   rd_ptr_o
);

    // One extra bit so a full queue is representable
    localparam int CNT_W = $clog2(`STB_DEPTH) + 1;

    stb_ptr_t         wr_ptr_q;
    stb_ptr_t         rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Tail advances on every push
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (ctrl.wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // Head advances on every pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
        end else if (ctrl.rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({ctrl.wr_en, ctrl.rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign ctrl.full  = (count_q == CNT_W'(`STB_DEPTH));
    assign ctrl.empty = (count_q == '0);
    assign wr_ptr_o   = wr_ptr_q;
    assign rd_ptr_o   = rd_ptr_q;

    // LSU controller must honour back-pressure
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.full |-> !ctrl.wr_en);

    // Drain controller never pops a missing entry
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.empty |-> !ctrl.rd_en);

endmodule

//--- stb_storage.sv
// Store buffer entry array
`timescale 1ns/1ps
`include "stb_cfg.svh"

module stb_storage
    import stb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Write side, from LSU controller and tail pointer
    input  logic       wr_en_i,
    input  stb_ptr_t   wr_ptr_i,
    input  stb_entry_t wr_entry_i,
    // Read side, head pointer
    input  stb_ptr_t   rd_ptr_i,
    output stb_entry_t head_o
);

    // Queue slots
    stb_entry_t mem_q [`STB_DEPTH];

    // Store lands in the tail slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `STB_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_ptr_i] <= wr_entry_i;
        end
    end

    // Oldest store, visible without a read cycle
    assign head_o = mem_q[rd_ptr_i];

endmodule

//--- lsu_stb_ctrl.sv
// LSU side store acceptance FSM
`timescale 1ns/1ps

module lsu_stb_ctrl
    import stb_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // LSU request qualifiers
    input  logic       lsu_req_i,
    input  logic       lsu_w_en_i,
    input  logic       dmem_sel_i,
    // Queue push and full status
    stb_ctrl_if.lsu_mp ctrl,
    // Store accepted
    output logic       stb_ack_o
);

    lsu_state_e state_q;
    lsu_state_e state_d;
    logic       store_req;

    // Only data memory stores enter the queue
    assign store_req = lsu_req_i & lsu_w_en_i & dmem_sel_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LSU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Push once in IDLE, then one ack cycle
    always_comb begin
        state_d    = state_q;
        ctrl.wr_en = 1'b0;
        case (state_q)
            LSU_IDLE: begin
                // Full holds the LSU here without ack
                if (store_req && !ctrl.full) begin
                    ctrl.wr_en = 1'b1;
                    state_d    = LSU_ACK;
                end
            end
            LSU_ACK: begin
                // LSU drops its request after this cycle
                state_d = LSU_IDLE;
            end
            default: begin
                state_d = LSU_IDLE;
            end
        endcase
    end

    // Ack straight from state, one cycle after the push
    assign stb_ack_o = (state_q == LSU_ACK);

    // Request drops after the ack so a store is pushed only once
    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        stb_ack_o |=> !lsu_req_i);

endmodule

//--- stb_drain_ctrl.sv
// Cache side drain FSM
`timescale 1ns/1ps

module stb_drain_ctrl
    import stb_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // Queue pop and empty status
    stb_ctrl_if.drain_mp ctrl,
    // Oldest entry from storage
    input  stb_entry_t   head_i,
    // Cache handshake
    input  logic         dc_ack_i,
    output logic         dc_req_o,
    output logic         dc_w_en_o,
    output stb_entry_t   dc_entry_o,
    output logic         dmem_sel_o
);

    drain_state_e state_q;
    drain_state_e state_d;
    logic         in_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DRAIN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign in_req = (state_q == DRAIN_REQ);

    // Request while pending, pop on cache ack
    always_comb begin
        state_d    = state_q;
        ctrl.rd_en = 1'b0;
        case (state_q)
            DRAIN_IDLE: begin
                if (!ctrl.empty) begin
                    state_d = DRAIN_REQ;
                end
            end
            DRAIN_REQ: begin
                // Cache may stall for any number of cycles
                if (dc_ack_i) begin
                    ctrl.rd_en = 1'b1;
                    state_d    = DRAIN_IDLE;
                end
            end
            default: begin
                state_d = DRAIN_IDLE;
            end
        endcase
    end

    // Every drain access is a data memory write
    assign dc_req_o   = in_req;
    assign dc_w_en_o  = in_req;
    assign dmem_sel_o = in_req;

    // Head only moves on pop, so the fields hold steady
    assign dc_entry_o = head_i;

    // Request and payload stay put until the cache answers
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        dc_req_o && !dc_ack_i |=> dc_req_o && $stable(dc_entry_o));

endmodule

//--- store_buffer_top.sv
// Store buffer between LSU and data cache
`timescale 1ns/1ps
`include "stb_cfg.svh"

module store_buffer_top
    import stb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // LSU request
    input  logic                   lsu_req_i,
    input  logic                   lsu_w_en_i,
    input  logic [`STB_ADDR_W-1:0] lsu_addr_i,
    input  logic [`STB_DATA_W-1:0] lsu_wdata_i,
    input  logic [`STB_SEL_W-1:0]  lsu_sel_byte_i,
    input  logic                   dmem_sel_i,
    // LSU response
    output logic                   lsu_ack_o,
    output logic [`STB_DATA_W-1:0] lsu_rdata_o,
    // Cache request
    output logic                   dc_req_o,
    output logic                   dc_w_en_o,
    output logic [`STB_ADDR_W-1:0] dc_addr_o,
    output logic [`STB_DATA_W-1:0] dc_wdata_o,
    output logic [`STB_SEL_W-1:0]  dc_sel_byte_o,
    output logic                   dmem_sel_o,
    output logic                   stb_empty_o,
    // Cache response
    input  logic                   dc_ack_i,
    input  logic [`STB_DATA_W-1:0] dc_rdata_i
);

    stb_ptr_t   wr_ptr;
    stb_ptr_t   rd_ptr;
    stb_entry_t wr_entry;
    stb_entry_t head;
    stb_entry_t drn_entry;
    logic       stb_ack;
    logic       drn_req;
    logic       drn_w_en;
    logic       drn_dmem_sel;
    logic       empty_q;
    logic       st_q;
    logic       ld_bypass;

    stb_ctrl_if ctrl_if ();

    assign wr_entry = '{addr: lsu_addr_i, wdata: lsu_wdata_i, sel_byte: lsu_sel_byte_i};

    // Empty history and last-cycle store request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_q <= 1'b1;
            st_q    <= 1'b0;
        end else begin
            empty_q <= ctrl_if.empty;
            st_q    <= lsu_req_i & lsu_w_en_i;
        end
    end

    // Loads go direct only on a quiet, empty buffer
    assign ld_bypass = empty_q & ~st_q & ~(lsu_req_i & lsu_w_en_i);

    stb_ptr_counter u_ptr (.clk(clk), .rst_n(rst_n), .ctrl(ctrl_if.ptr_mp),
                           .wr_ptr_o(wr_ptr), .rd_ptr_o(rd_ptr));

    stb_storage u_storage (.clk(clk), .rst_n(rst_n), .wr_en_i(ctrl_if.wr_en),
                           .wr_ptr_i(wr_ptr), .wr_entry_i(wr_entry),
                           .rd_ptr_i(rd_ptr), .head_o(head));

    lsu_stb_ctrl u_lsu_ctrl (.clk(clk), .rst_n(rst_n), .lsu_req_i(lsu_req_i),
                             .lsu_w_en_i(lsu_w_en_i), .dmem_sel_i(dmem_sel_i),
                             .ctrl(ctrl_if.lsu_mp), .stb_ack_o(stb_ack));

    stb_drain_ctrl u_drain_ctrl (.clk(clk), .rst_n(rst_n), .ctrl(ctrl_if.drain_mp),
                                 .head_i(head), .dc_ack_i(dc_ack_i), .dc_req_o(drn_req),
                                 .dc_w_en_o(drn_w_en), .dc_entry_o(drn_entry),
                                 .dmem_sel_o(drn_dmem_sel));

    assign stb_empty_o = empty_q;

    // Drain path by default, LSU load straight through on bypass
    always_comb begin
        lsu_ack_o     = stb_ack;
        lsu_rdata_o   = '0;
        dc_req_o      = drn_req;
        dc_w_en_o     = drn_w_en;
        dc_addr_o     = drn_entry.addr;
        dc_wdata_o    = drn_entry.wdata;
        dc_sel_byte_o = drn_entry.sel_byte;
        dmem_sel_o    = drn_dmem_sel;
        if (ld_bypass) begin
            lsu_ack_o     = dc_ack_i;
            lsu_rdata_o   = dc_rdata_i;
            dc_req_o      = lsu_req_i;
            dc_w_en_o     = 1'b0;
            dc_addr_o     = lsu_addr_i;
            dc_wdata_o    = lsu_wdata_i;
            dc_sel_byte_o = lsu_sel_byte_i;
            dmem_sel_o    = dmem_sel_i;
        end
    end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a clock edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- tb_store_buffer.sv
// Store buffer testbench
`timescale 1ns/1ps
`include "stb_cfg.svh"

module tb_store_buffer
    import stb_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_LINES  = 32;

    logic clk, rst_n, lsu_req_i, lsu_w_en_i, dmem_sel_i, lsu_ack_o;
    logic [`STB_ADDR_W-1:0] lsu_addr_i, dc_addr_o;
    logic [`STB_DATA_W-1:0] lsu_wdata_i, lsu_rdata_o, dc_wdata_o;
    logic [`STB_SEL_W-1:0]  lsu_sel_byte_i, dc_sel_byte_o;
    logic dc_req_o, dc_w_en_o, dmem_sel_o, stb_empty_o;
    logic                   dc_ack_i = 1'b0;
    logic [`STB_DATA_W-1:0] dc_rdata_i = '0;

    // Six words per line: op, addr, data, sel, latency, expected load data
    logic [31:0] stim [0:6*MAX_LINES-1];
    logic [31:0] mem [0:1023];
    stb_entry_t  sb [$];
    int n_lines, max_lat, limit_ns, cur_lat, wait_cnt, acked_cnt, written_cnt, max_out;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(10)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

    store_buffer_top store_buffer_top_i (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Oldest acknowledged store must be the one reaching the cache
    task automatic check_cache_write();
        stb_entry_t exp_e;
        if (sb.size() == 0) begin
            fail_run("Cache write seen while no acknowledged store was pending");
        end else begin
            exp_e = sb.pop_front();
            check_val("drain_addr", exp_e.addr, dc_addr_o);
            check_val("drain_wdata", exp_e.wdata, dc_wdata_o);
            check_val("drain_sel", 32'(exp_e.sel_byte), 32'(dc_sel_byte_o));
            for (int b = 0; b < `STB_SEL_W; b++) begin
                if (dc_sel_byte_o[b]) begin
                    mem[dc_addr_o[11:2]][8*b +: 8] = dc_wdata_o[8*b +: 8];
                end
            end
        end
    endtask

    // Cache model, ack after the latency of the current line
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_ack_i <= 1'b0;
            wait_cnt <= 0;
        end else if (dc_ack_i) begin
            dc_ack_i <= 1'b0;
            wait_cnt <= 0;
        end else if (dc_req_o) begin
            if (wait_cnt >= cur_lat) begin
                dc_ack_i <= 1'b1;
                // Every access in this test targets data memory
                check_val("dc_dmem_sel", 1, dmem_sel_o);
                if (dc_w_en_o) begin
                    check_cache_write();
                    written_cnt <= written_cnt + 1;
                end else begin
                    dc_rdata_i <= mem[dc_addr_o[11:2]];
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    task automatic wait_for_lsu_ack();
        do @(posedge clk); while (lsu_ack_o !== 1'b1);
    endtask

    task automatic drive_request(input int ln, input logic w_en);
        @(posedge clk);
        cur_lat        <= stim[6*ln+4];
        lsu_req_i      <= 1'b1;
        lsu_w_en_i     <= w_en;
        lsu_addr_i     <= stim[6*ln+1];
        lsu_wdata_i    <= stim[6*ln+2];
        lsu_sel_byte_i <= stim[6*ln+3][`STB_SEL_W-1:0];
        dmem_sel_i     <= 1'b1;
        wait_for_lsu_ack();
    endtask

    // Acked store goes to the scoreboard, at most DEPTH may be unwritten
    task automatic drive_store(input int ln);
        int outstanding;
        drive_request(ln, 1'b1);
        acked_cnt++;
        sb.push_back('{addr: lsu_addr_i, wdata: lsu_wdata_i, sel_byte: lsu_sel_byte_i});
        outstanding = acked_cnt - written_cnt;
        if (outstanding > max_out) begin
            max_out = outstanding;
        end
        check_val($sformatf("store_backpressure line %0d", ln), 1, outstanding <= `STB_DEPTH);
        lsu_req_i  <= 1'b0;
        lsu_w_en_i <= 1'b0;
    endtask

    // Load ack only once every earlier store reached the cache
    task automatic drive_load(input int ln);
        drive_request(ln, 1'b0);
        check_val($sformatf("load_empty line %0d", ln), 1, stb_empty_o);
        check_val($sformatf("load_drained line %0d", ln), acked_cnt, written_cnt);
        check_val($sformatf("load_data line %0d", ln), stim[6*ln+5], lsu_rdata_o);
        lsu_req_i <= 1'b0;
    endtask

    initial begin
        lsu_req_i = 1'b0;
        lsu_w_en_i = 1'b0;
        lsu_addr_i = '0;
        lsu_wdata_i = '0;
        lsu_sel_byte_i = '0;
        dmem_sel_i = 1'b0;
        cur_lat = 0;
        acked_cnt = 0;
        written_cnt = 0;
        max_out = 0;
        n_lines = 0;
        max_lat = 0;
        // Fill pattern from the full byte address of each word
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (i * 4) ^ 32'h5A5A_C3C3;
        end
        $readmemh("stb_stim.txt", stim);
        while (n_lines < MAX_LINES && !$isunknown(stim[6*n_lines])) begin
            if (stim[6*n_lines+4] > max_lat) max_lat = stim[6*n_lines+4];
            n_lines++;
        end
        if (n_lines == 0) begin
            fail_run("No stimulus lines could be read from stb_stim.txt");
        end
        limit_ns = n_lines * (`STB_DEPTH + max_lat + 6) * CLK_PERIOD;
        wait (rst_n === 1'b1);
        @(posedge clk);
        check_val("reset_empty", 1, stb_empty_o);
        check_val("reset_dc_req", 0, dc_req_o);
        check_val("reset_lsu_ack", 0, lsu_ack_o);
        check_val("reset_dmem_sel", 0, dmem_sel_o);
        for (int ln = 0; ln < n_lines; ln++) begin
            case (stim[6*ln])
                32'd0: begin
                    @(posedge clk);
                    cur_lat <= stim[6*ln+4];
                    repeat (stim[6*ln+4]) @(posedge clk);
                end
                32'd1: drive_store(ln);
                32'd2: drive_load(ln);
                default: fail_run($sformatf("Unknown operation code on line %0d", ln));
            endcase
        end
        check_val("backpressure_depth", `STB_DEPTH, max_out);
        $display("Test completed successfully");
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        fail_run($sformatf("Run timed out after %0d ns before all lines finished", limit_ns));
    end

endmodule

//--- stb_stim.txt
// op addr data sel lat expect (hex words)
// op 0 idle for lat cycles, 1 store, 2 load; lat is cache ack latency
2 00000100 00000000 F 02 5A5AC2C3
1 00000100 11223344 F 03 00000000
1 00000104 AABBCCDD 3 03 00000000
2 00000104 00000000 F 03 5A5ACCDD
0 00000000 00000000 0 04 00000000
1 00000108 01020304 F 14 00000000
1 00000108 0000FF00 2 14 00000000
1 00000100 99000000 8 14 00000000
1 00000200 CAFEF00D C 14 00000000
1 00000200 12345678 1 14 00000000
2 00000108 00000000 F 02 0102FF04
2 00000200 00000000 F 02 CAFEC178
2 00000100 00000000 F 01 99223344
1 00000104 55667788 C 00 00000000
2 00000104 00000000 F 00 5566CCDD
0 00000000 00000000 0 02 00000000

//--- flist.f
+incdir+.
stb_pkg.sv
stb_ctrl_if.sv
stb_ptr_counter.sv
stb_storage.sv
lsu_stb_ctrl.sv
stb_drain_ctrl.sv
store_buffer_top.sv
tb_clk_gen.sv
tb_store_buffer.sv
